// ==== logic/percVarPkg.sv ====
package percVarPkg;

	//////////////////////////////
	// Memory and vector sizes
	//////////////////////////////
	localparam int AddrWidth = 11;
	localparam int DataWidth = 32;
	localparam int LsfCount = 10;
	localparam int IndexWidth = 4;

	// Q15 sample
	typedef logic signed [15:0] q15_t;

	typedef enum logic [1:0]
	{
		aluSub,
		aluAdd,
		aluMin,
		aluMulInt
	} aluOp_t;

	typedef enum logic [2:0]
	{
		stIdle,
		stRead,
		stScale,
		stFinish,
		stWriteG2,
		stWriteG1
	} ctrlState_t;

	// One memory request, test side or design side
	typedef struct packed
	{
		logic [AddrWidth-1:0] writeAddr;
		logic [AddrWidth-1:0] readAddr;
		logic [DataWidth-1:0] writeData;
		logic writeEnable;
	} memPort_t;

	//////////////////////////////
	// Weighting constants in Q15
	//////////////////////////////
	localparam q15_t Gamma1Flat = 16'sd32113;
	localparam q15_t Gamma1Tilt = 16'sd30802;
	localparam q15_t Gamma2Max = 16'sd22938;
	localparam q15_t Gamma2Min = 16'sd13107;
	localparam q15_t GammaOne = 16'sd32767;

	// Clip a wide signed value into the Q15 range
	function automatic q15_t saturate32(input logic signed [31:0] value);
		q15_t clipped;
		if (value > 32'sd32767)
			clipped = 16'sh7fff;
		else if (value < -32'sd32768)
			clipped = 16'sh8000;
		else
			clipped = q15_t'(value[15:0]);
		return clipped;
	endfunction

	function automatic q15_t satSub(input q15_t a, input q15_t b);
		logic signed [31:0] wide;
		wide = 32'(a) - 32'(b);
		return saturate32(wide);
	endfunction

endpackage

// ==== logic/q15Alu.sv ====
`timescale 1ns/1ps

module q15Alu import percVarPkg::*;
(
	input aluOp_t op,
	input q15_t a,
	input q15_t b,
	output q15_t result
);

	logic signed [31:0] wideSum;
	logic signed [31:0] wideProduct;

	//////////////////////////////
	// Full-width intermediates
	//////////////////////////////
	always_comb
	begin
		wideSum = 32'(a) + 32'(b);
		// Multiplier operand is a small integer, not a Q15 fraction
		wideProduct = 32'(a) * 32'(b);
	end

	//////////////////////////////
	// Operator select
	//////////////////////////////
	always_comb
	begin
		case (op)
			aluSub:
			begin
				result = satSub(a, b);
			end
			aluAdd:
			begin
				result = saturate32(wideSum);
			end
			aluMin:
			begin
				// Signed compare, ties keep a
				result = (b < a) ? b : a;
			end
			aluMulInt:
			begin
				result = saturate32(wideProduct);
			end
			default:
			begin
				result = a;
			end
		endcase
	end

endmodule

// ==== logic/scratchMemory.sv ====
`timescale 1ns/1ps

module scratchMemory import percVarPkg::*;
(
	input logic clk,
	input logic testMode,
	input memPort_t testPort,
	input memPort_t corePort,
	output logic [DataWidth-1:0] readData
);

	logic [DataWidth-1:0] memArray [2**AddrWidth];

	logic [AddrWidth-1:0] selReadAddr;
	logic [AddrWidth-1:0] selWriteAddr;
	logic [DataWidth-1:0] selWriteData;
	logic selWriteEnable;

	//////////////////////////////
	// Test or design side request
	//////////////////////////////
	always_comb
	begin
		case (testMode)
			1'b1:
			begin
				selReadAddr = testPort.readAddr;
				selWriteAddr = testPort.writeAddr;
				selWriteData = testPort.writeData;
				selWriteEnable = testPort.writeEnable;
			end
			default:
			begin
				selReadAddr = corePort.readAddr;
				selWriteAddr = corePort.writeAddr;
				selWriteData = corePort.writeData;
				selWriteEnable = corePort.writeEnable;
			end
		endcase
	end

	// Port A writes, port B reads one cycle late
	always_ff @(posedge clk)
	begin
		if (selWriteEnable)
			memArray[selWriteAddr] <= selWriteData;
		readData <= memArray[selReadAddr];
	end

endmodule

// ==== logic/lsfIndexCounter.sv ====
`timescale 1ns/1ps

module lsfIndexCounter import percVarPkg::*;
#(
	parameter int LsfBase = 0
)
(
	input logic clk,
	input logic rstN,
	input logic clear,
	input logic step,
	output logic [IndexWidth-1:0] index,
	output logic [AddrWidth-1:0] readAddr,
	output logic last
);

	always_ff @(posedge clk)
	begin
		if (!rstN)
			index <= '0;
		else if (clear)
			index <= '0;
		else if (step)
			index <= index + 1'b1;
	end

	// LSF words are contiguous from the base
	assign readAddr = AddrWidth'(LsfBase) + AddrWidth'(index);

	assign last = (index == IndexWidth'(LsfCount - 1));

endmodule

// ==== logic/percVarControl.sv ====
`timescale 1ns/1ps

module percVarControl import percVarPkg::*;
(
	input logic clk,
	input logic rstN,
	input logic start,
	input logic testMode,
	input logic last,
	output logic counterClear,
	output logic counterStep,
	output logic loadFirst,
	output logic loadDiff,
	output logic loadScale,
	output logic loadFinal,
	output aluOp_t aluOp,
	output logic writeEnable,
	output logic writeSelect,
	output logic busy,
	output logic done
);

	ctrlState_t state;
	ctrlState_t nextState;

	logic stepDly;
	logic firstDly;

	//////////////////////////////
	// State register
	//////////////////////////////
	always_ff @(posedge clk)
	begin
		if (!rstN)
			state <= stIdle;
		else
			state <= nextState;
	end

	always_comb
	begin
		nextState = state;
		case (state)
			stIdle:
			begin
				if (start && !testMode)
					nextState = stRead;
			end
			stRead:
			begin
				if (last)
					nextState = stScale;
			end
			stScale:
			begin
				// Wait out the last read before scaling
				if (!stepDly)
					nextState = stFinish;
			end
			stFinish:
				nextState = stWriteG2;
			stWriteG2:
				nextState = stWriteG1;
			stWriteG1:
				nextState = stIdle;
			default:
				nextState = stIdle;
		endcase
	end

	assign counterClear = (state == stIdle);
	assign counterStep = (state == stRead);

	//////////////////////////////
	// Load strobes lag reads by one
	//////////////////////////////
	always_ff @(posedge clk)
	begin
		if (!rstN)
		begin
			stepDly <= 1'b0;
			firstDly <= 1'b0;
		end
		else
		begin
			stepDly <= counterStep;
			firstDly <= counterStep && !stepDly;
		end
	end

	assign loadFirst = firstDly;
	assign loadDiff = stepDly && !firstDly;
	assign loadScale = (state == stScale) && !stepDly;
	assign loadFinal = (state == stFinish);

	// Opcode per phase
	always_comb
	begin
		if (loadDiff)
			aluOp = aluMin;
		else if (loadScale)
			aluOp = aluMulInt;
		else
			aluOp = aluSub;
	end

	assign writeEnable = (state == stWriteG2) || (state == stWriteG1);
	assign writeSelect = (state == stWriteG1);
	assign busy = (state != stIdle);
	assign done = (state == stWriteG1);

endmodule

// ==== logic/percVarDatapath.sv ====
`timescale 1ns/1ps

module percVarDatapath import percVarPkg::*;
#(
	parameter int ResultBase = 16,
	parameter int FlatThreshold = 1000
)
(
	input logic clk,
	input logic rstN,
	input logic [DataWidth-1:0] readData,
	input logic loadFirst,
	input logic loadDiff,
	input logic loadScale,
	input logic loadFinal,
	input logic writeSelect,
	input logic writeEnable,
	input q15_t aluResult,
	output q15_t aluA,
	output q15_t aluB,
	output memPort_t corePortWrite,
	output q15_t gamma1,
	output q15_t gamma2
);

	localparam q15_t ScaleFactor = 16'sd6;

	q15_t lsfNow;
	q15_t prevLsf;
	q15_t dMin;
	q15_t acc;
	q15_t gamma2Clamped;

	assign lsfNow = q15_t'(readData[15:0]);

	//////////////////////////////
	// Operand routing
	//////////////////////////////
	always_comb
	begin
		if (loadDiff)
		begin
			// Gap to the previous LSF, then minimum against dMin
			aluA = satSub(lsfNow, prevLsf);
			aluB = dMin;
		end
		else if (loadScale)
		begin
			aluA = dMin;
			aluB = ScaleFactor;
		end
		else
		begin
			aluA = GammaOne;
			aluB = acc;
		end
	end

	always_ff @(posedge clk)
	begin
		if (loadFirst || loadDiff)
			prevLsf <= lsfNow;
		if (loadFirst)
			dMin <= GammaOne;
		else if (loadDiff)
			dMin <= aluResult;
		if (loadScale)
			acc <= aluResult;
	end

	// Keep gamma2 within 0.4 to 0.7
	always_comb
	begin
		if (aluResult > Gamma2Max)
			gamma2Clamped = Gamma2Max;
		else if (aluResult < Gamma2Min)
			gamma2Clamped = Gamma2Min;
		else
			gamma2Clamped = aluResult;
	end

	always_ff @(posedge clk)
	begin
		if (!rstN)
		begin
			gamma1 <= '0;
			gamma2 <= '0;
		end
		else if (loadFinal)
		begin
			gamma2 <= gamma2Clamped;
			gamma1 <= (dMin >= FlatThreshold) ? Gamma1Flat : Gamma1Tilt;
		end
	end

	//////////////////////////////
	// Write-back request
	//////////////////////////////
	assign corePortWrite.writeAddr = AddrWidth'(ResultBase) + AddrWidth'(writeSelect);
	assign corePortWrite.readAddr = '0;
	assign corePortWrite.writeData = {16'b0, writeSelect ? gamma1 : gamma2};
	assign corePortWrite.writeEnable = writeEnable;

endmodule

// ==== logic/percVarTop.sv ====
`timescale 1ns/1ps

module percVarTop import percVarPkg::*;
#(
	parameter int LsfBase = 0,
	parameter int ResultBase = 16,
	parameter int FlatThreshold = 1000
)
(
	input logic clk,
	input logic rstN,
	input logic testMode,
	input logic start,
	input memPort_t testPort,
	output logic [DataWidth-1:0] testReadData,
	output q15_t gamma1,
	output q15_t gamma2,
	output logic done,
	output logic busy
);

	logic counterClear;
	logic counterStep;
	logic [AddrWidth-1:0] readAddr;
	logic last;
	logic loadFirst;
	logic loadDiff;
	logic loadScale;
	logic loadFinal;
	logic writeEnable;
	logic writeSelect;
	aluOp_t aluOp;
	q15_t aluA;
	q15_t aluB;
	q15_t aluResult;
	memPort_t corePortWrite;
	memPort_t corePort;

	// Read address from the counter, write side from the datapath
	assign corePort = '{
		writeAddr: corePortWrite.writeAddr,
		readAddr: readAddr,
		writeData: corePortWrite.writeData,
		writeEnable: corePortWrite.writeEnable
	};

	scratchMemory memory_i (
		.clk(clk),
		.testMode(testMode),
		.testPort(testPort),
		.corePort(corePort),
		.readData(testReadData)
	);

	lsfIndexCounter #(.LsfBase(LsfBase)) counter_i (
		.clk(clk),
		.rstN(rstN),
		.clear(counterClear),
		.step(counterStep),
		.index(),
		.readAddr(readAddr),
		.last(last)
	);

	percVarControl control_i (
		.clk(clk),
		.rstN(rstN),
		.start(start),
		.testMode(testMode),
		.last(last),
		.counterClear(counterClear),
		.counterStep(counterStep),
		.loadFirst(loadFirst),
		.loadDiff(loadDiff),
		.loadScale(loadScale),
		.loadFinal(loadFinal),
		.aluOp(aluOp),
		.writeEnable(writeEnable),
		.writeSelect(writeSelect),
		.busy(busy),
		.done(done)
	);

	percVarDatapath #(
		.ResultBase(ResultBase),
		.FlatThreshold(FlatThreshold)
	) datapath_i (
		.clk(clk),
		.rstN(rstN),
		.readData(testReadData),
		.loadFirst(loadFirst),
		.loadDiff(loadDiff),
		.loadScale(loadScale),
		.loadFinal(loadFinal),
		.writeSelect(writeSelect),
		.writeEnable(writeEnable),
		.aluResult(aluResult),
		.aluA(aluA),
		.aluB(aluB),
		.corePortWrite(corePortWrite),
		.gamma1(gamma1),
		.gamma2(gamma2)
	);

	q15Alu alu_i (
		.op(aluOp),
		.a(aluA),
		.b(aluB),
		.result(aluResult)
	);

endmodule

// ==== testbench/tbClock.sv ====
`timescale 1ns/1ps

module tbClock
#(
	parameter int HalfPeriod = 20,
	parameter int ResetCycles = 16
)
(
	output logic clk,
	output logic rstN
);

	// 40 ns period
	initial
	begin
		clk = 1'b0;
		forever
			#(HalfPeriod) clk = ~clk;
	end

	// Reset released on a rising edge
	initial
	begin
		rstN = 1'b0;
		repeat (ResetCycles)
			@(posedge clk);
		rstN <= 1'b1;
	end

endmodule

// ==== testbench/percVar_assertions.sv ====
`timescale 1ns/1ps

module percVar_assertions
(
	input logic clk,
	input logic rstN,
	input logic start,
	input logic testMode,
	input logic busy,
	input logic done,
	input logic writeEnable,
	input logic writeSelect
);

	logic accepted;

	// Start only counts from idle with the test side released
	assign accepted = start && !testMode && !busy;

	//////////////////////////////
	// Run timing
	//////////////////////////////
	doneAfterStart: assert property (@(posedge clk) disable iff (!rstN)
		$past(accepted, 15) |-> (done && writeEnable && writeSelect))
		else $error("done and the gamma1 write did not follow an accepted start by 15 cycles");

	doneHasStart: assert property (@(posedge clk) disable iff (!rstN)
		done |-> $past(accepted, 15))
		else $error("done pulsed without a start 15 cycles earlier");

	// Gamma2 goes out one cycle ahead of gamma1
	gamma2Write: assert property (@(posedge clk) disable iff (!rstN)
		$past(accepted, 14) |-> (writeEnable && !writeSelect))
		else $error("gamma2 write missing 14 cycles after an accepted start");

	// Writes only at the end of a run
	writeInRun: assert property (@(posedge clk) disable iff (!rstN)
		writeEnable |-> ($past(accepted, 14) || $past(accepted, 15)))
		else $error("memory write enable raised outside the result writes");

	resetIdle: assert property (@(posedge clk)
		!rstN |=> (!done && !busy && !writeEnable))
		else $error("controller outputs active after reset");

endmodule

bind percVarControl percVar_assertions assertions_i (
	.clk(clk),
	.rstN(rstN),
	.start(start),
	.testMode(testMode),
	.busy(busy),
	.done(done),
	.writeEnable(writeEnable),
	.writeSelect(writeSelect)
);

// ==== testbench/percVarTb.sv ====
`timescale 1ns/1ps

module percVarTb import percVarPkg::*;
;

	localparam int LsfBase = 0;
	localparam int ResultBase = 16;
	localparam int FlatThreshold = 1000;
	localparam int RunLatency = 15;
	localparam int CyclesPerTest = 40;
	localparam int CycleMargin = 100;
	localparam int ReadCount = LsfCount + 2;
	localparam int TokenBits = 8 * 32;

	// One vector from the input file
	typedef struct packed
	{
		q15_t [LsfCount-1:0] lsf;
		q15_t gamma1;
		q15_t gamma2;
	} testVector_t;

	logic clk;
	logic rstN;
	logic testMode;
	logic start;
	memPort_t testPort;
	logic [DataWidth-1:0] testReadData;
	q15_t gamma1;
	q15_t gamma2;
	logic done;
	logic busy;

	testVector_t vectors[$];
	string names[$];
	int cycleCount = 0;
	int cycleLimit = 0;
	int seed = 4;

	tbClock clock_i (
		.clk(clk),
		.rstN(rstN)
	);

	percVarTop #(
		.LsfBase(LsfBase),
		.ResultBase(ResultBase),
		.FlatThreshold(FlatThreshold)
	) dut_i (
		.clk(clk),
		.rstN(rstN),
		.testMode(testMode),
		.start(start),
		.testPort(testPort),
		.testReadData(testReadData),
		.gamma1(gamma1),
		.gamma2(gamma2),
		.done(done),
		.busy(busy)
	);

	//////////////////////////////
	// Failure reporting and checks
	//////////////////////////////
	task automatic abortRun(input string reason);
		$display("%s", reason);
		$display("SIMULATION FAILED");
		$fatal(1, "Run stopped");
	endtask

	task automatic checkGamma(input string testName, input string what,
		input q15_t expected, input q15_t actual);
		if (actual !== expected)
			abortRun($sformatf("Mismatch in %s, %s: expected %0d, actual %0d",
				testName, what, expected, actual));
	endtask

	task automatic checkWord(input string testName, input string what,
		input logic [DataWidth-1:0] expected, input logic [DataWidth-1:0] actual);
		if (actual !== expected)
			abortRun($sformatf("Mismatch in %s, %s: expected 0x%08h, actual 0x%08h",
				testName, what, expected, actual));
	endtask

	task automatic checkFlag(input string testName, input string what,
		input logic expected, input logic actual);
		if (actual !== expected)
			abortRun($sformatf("Mismatch in %s, %s: expected %b, actual %b",
				testName, what, expected, actual));
	endtask

	task automatic checkCycles(input string testName, input int expected, input int actual);
		if (actual != expected)
			abortRun($sformatf("Mismatch in %s, start to done: expected %0d, actual %0d",
				testName, expected, actual));
	endtask

	// Watchdog
	always @(posedge clk)
	begin
		cycleCount <= cycleCount + 1;
		if (cycleLimit > 0 && cycleCount >= cycleLimit)
			abortRun($sformatf("Timeout, the run did not end within %0d cycles", cycleLimit));
	end

	//////////////////////////////
	// Vector file
	//////////////////////////////
	task automatic loadVectors();
		int fd;
		int code;
		int j;
		int lsfVal [LsfCount];
		int g1Val;
		int g2Val;
		logic [TokenBits-1:0] token;
		logic [8*160-1:0] skipLine;
		testVector_t vec;
		fd = $fopen("testbench/percVarInput.txt", "r");
		if (fd == 0)
			abortRun("Could not open testbench/percVarInput.txt");
		while (!$feof(fd))
		begin
			code = $fscanf(fd, "%s", token);
			if (code == 1)
			begin
				if (token == TokenBits'("#"))
					code = $fgets(skipLine, fd);
				else
				begin
					code = $fscanf(fd, "%d %d %d %d %d %d %d %d %d %d %d %d",
						lsfVal[0], lsfVal[1], lsfVal[2], lsfVal[3], lsfVal[4],
						lsfVal[5], lsfVal[6], lsfVal[7], lsfVal[8], lsfVal[9],
						g1Val, g2Val);
					if (code != LsfCount + 2)
						abortRun($sformatf("Incomplete vector line for %0s", token));
					for (j = 0; j < LsfCount; j++)
						vec.lsf[j] = q15_t'(lsfVal[j]);
					vec.gamma1 = q15_t'(g1Val);
					vec.gamma2 = q15_t'(g2Val);
					vectors.push_back(vec);
					names.push_back($sformatf("%0s", token));
				end
			end
		end
		$fclose(fd);
	endtask

	//////////////////////////////
	// One subframe
	//////////////////////////////
	task automatic runTest(input string testName, input testVector_t vec);
		int gap;
		int latency;
		int j;
		logic [AddrWidth-1:0] readAddrs [ReadCount];
		logic [DataWidth-1:0] expectWords [ReadCount];
		// Results first, then the LSFs that must be untouched
		readAddrs[0] = AddrWidth'(ResultBase);
		readAddrs[1] = AddrWidth'(ResultBase + 1);
		expectWords[0] = {16'h0000, vec.gamma2};
		expectWords[1] = {16'h0000, vec.gamma1};
		for (j = 0; j < LsfCount; j++)
		begin
			readAddrs[j + 2] = AddrWidth'(LsfBase + j);
			expectWords[j + 2] = {16'h0000, vec.lsf[j]};
		end
		gap = $random(seed) & 3;
		repeat (gap)
			@(posedge clk);

		// Preload through the test port
		for (j = 0; j < LsfCount; j++)
		begin
			@(posedge clk);
			testPort <= '{
				writeAddr: AddrWidth'(LsfBase + j),
				readAddr: '0,
				writeData: {16'h0000, vec.lsf[j]},
				writeEnable: 1'b1
			};
		end
		@(posedge clk);
		testPort <= '0;
		testMode <= 1'b0;
		start <= 1'b1;
		@(posedge clk);
		start <= 1'b0;
		latency = 0;
		do
		begin
			@(posedge clk);
			latency++;
			checkFlag(testName, "busy in run", 1'b1, busy);
			// Extra start in mid run
			start <= (latency == 5);
		end
		while (!done);
		checkCycles(testName, RunLatency, latency);
		checkGamma(testName, "gamma1 port", vec.gamma1, gamma1);
		checkGamma(testName, "gamma2 port", vec.gamma2, gamma2);

		// Read back results and LSFs, data lags the address by one
		testMode <= 1'b1;
		for (j = 0; j < ReadCount + 2; j++)
		begin
			if (j > 0)
				@(posedge clk);
			if (j < ReadCount)
				testPort <= '{writeAddr: '0, readAddr: readAddrs[j], writeData: '0,
					writeEnable: 1'b0};
			if (j == 1)
			begin
				checkFlag(testName, "busy after done", 1'b0, busy);
				checkFlag(testName, "done pulse width", 1'b0, done);
			end
			if (j >= 2)
				checkWord(testName, $sformatf("memory word %0d", readAddrs[j - 2]),
					expectWords[j - 2], testReadData);
		end
	endtask

	initial
	begin
		int i;
		testMode = 1'b1;
		start = 1'b0;
		testPort = '0;
		loadVectors();
		if (vectors.size() == 0)
			abortRun("No test vectors found in the input file");
		cycleLimit = CyclesPerTest * vectors.size() + CycleMargin;

		do
			@(posedge clk);
		while (rstN !== 1'b1);
		checkFlag("reset", "done", 1'b0, done);
		checkFlag("reset", "busy", 1'b0, busy);
		checkGamma("reset", "gamma1 port", 16'sd0, gamma1);
		checkGamma("reset", "gamma2 port", 16'sd0, gamma2);

		for (i = 0; i < vectors.size(); i++)
			runTest(names[i], vectors[i]);

		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

// ==== testbench/percVarInput.txt ====
# name lsf0 lsf1 lsf2 lsf3 lsf4 lsf5 lsf6 lsf7 lsf8 lsf9 gamma1 gamma2
# all values decimal Q15, gamma1 and gamma2 are the expected results
# gaps below 1639 clamp gamma2 to 22938
tinyGap 1000 2000 2100 4000 6000 8000 10000 12000 14000 16000 30802 22938
zeroGap 2000 4000 4000 6000 8000 10000 12000 14000 16000 18000 30802 22938
atThreshold 500 1500 3000 5000 7000 9000 11000 13000 15000 17000 32113 22938
belowThreshold 500 1499 3000 5000 7000 9000 11000 13000 15000 17000 30802 22938
# gaps above 3276 clamp gamma2 to 13107
wideGap 0 3500 7000 10500 14000 17500 21000 24500 28000 31500 32113 13107
justAboveMin 100 3377 6700 10000 13300 16600 19900 23200 26500 29800 32113 13107
# in range
justBelowMax 1000 2639 5000 8000 11000 14000 17000 20000 23000 26000 32113 22933
justInsideMin 100 3376 6700 10000 13300 16600 19900 23200 26500 29800 32113 13111
evenGap 2000 4000 6000 8000 10000 12000 14000 16000 18000 20000 32113 20767
minFirst 1000 3500 6500 9500 12500 15500 18500 21500 24500 27500 32113 17767
minLast 1000 3500 6000 8500 11000 13500 16000 18500 21000 22800 32113 21967
oddGap 3000 5345 8000 11000 14000 17000 20000 23000 26000 29000 32113 18697
# unsorted, the 32000 to -32000 step saturates the difference
negWrap 1000 2000 3000 32000 -32000 -30000 -28000 -26000 -24000 -22000 30802 22938

// ==== files.f ====
logic/percVarPkg.sv
logic/q15Alu.sv
logic/scratchMemory.sv
logic/lsfIndexCounter.sv
logic/percVarControl.sv
logic/percVarDatapath.sv
logic/percVarTop.sv
testbench/tbClock.sv
testbench/percVar_assertions.sv
testbench/percVarTb.sv

// ==== Makefile ====
SIM = verilator
SIMFLAGS = --binary --timing --assert -j 0
TOP = percVarTb
FILELIST = files.f

BUILDDIR = obj_dir
BIN = $(BUILDDIR)/V$(TOP)
LOG = sim.log
SOURCES = $(shell cat $(FILELIST))
DATA = testbench/percVarInput.txt

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(SIMFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILDDIR)

run: $(BIN) $(DATA)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "SIMULATION FAILED" $(LOG); then echo "Run failed, see $(LOG)"; exit 1; fi
	@if ! grep -q "SIMULATION PASSED" $(LOG); then echo "Run ended early, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(BUILDDIR) $(LOG)
